// File: Makefile
TOP = tb_pwl_activation

.PHONY: all run lint clean

all: run

run:
	verilator --binary --timing --assert -f build.f --top-module $(TOP) -o sim_$(TOP)
	@out=$$(./obj_dir/sim_$(TOP)); echo "$$out"; echo "$$out" | grep -qx "RESULT: PASS"

lint:
	verilator --lint-only --timing --assert -f build.f --top-module pwl_activation

clean:
	rm -rf obj_dir

// File: build.f
pwl_pkg.sv
pwl_segment_select.sv
pwl_coeff_table.sv
fp_mul.sv
fp_add.sv
pwl_activation.sv
tb_pwl_activation.sv

// File: fp_add.sv
`timescale 1ns/100ps
`default_nettype none

module fp_add (
    input  logic                         clk,  // Assertion sampling only
    input  logic [pwl_pkg::fp_width-1:0] a,
    input  logic [pwl_pkg::fp_width-1:0] b,
    output logic [pwl_pkg::fp_width-1:0] s
);
    import pwl_pkg::*;

    logic [fp_width-1:0]  big_op;
    logic [fp_width-1:0]  small_op;
    logic [exp_width-1:0] exp_big;
    logic [exp_width-1:0] exp_small;
    logic [exp_width-1:0] exp_diff;
    logic [frac_width:0]  man_big;
    logic [frac_width:0]  man_small;
    logic [49:0]          shifted;
    logic [26:0]          aligned;   // Mantissa, guard, round, sticky
    logic [27:0]          sum;
    logic [4:0]           lz;
    logic [26:0]          norm;
    logic                 round_up;
    logic [frac_width+1:0] man_rnd;
    logic signed [9:0]    exp_res;

    function automatic logic [4:0] lzc27(logic [26:0] v);
        logic [4:0] n;
        logic       found;
        n     = 5'd0;
        found = 1'b0;
        for (int i = 26; i >= 0; i--) begin
            if (!found && v[i]) begin
                found = 1'b1;
                n     = 5'(26 - i);
            end
        end
        return n;
    endfunction

    always_comb begin
        // Order by magnitude so the difference is never negative
        if (a[fp_width-2:0] >= b[fp_width-2:0]) begin
            big_op   = a;
            small_op = b;
        end else begin
            big_op   = b;
            small_op = a;
        end
        exp_big   = big_op[fp_width-2 -: exp_width];
        exp_small = small_op[fp_width-2 -: exp_width];
        exp_diff  = exp_big - exp_small;
        man_big   = {1'b1, big_op[frac_width-1:0]};
        man_small = (exp_small == '0) ? '0 : {1'b1, small_op[frac_width-1:0]};

        shifted = {man_small, 26'd0} >> exp_diff;
        aligned = {shifted[49:24], |shifted[23:0]};

        if (big_op[fp_width-1] == small_op[fp_width-1]) begin
            sum = {1'b0, man_big, 3'b000} + {1'b0, aligned};
        end else begin
            sum = {1'b0, man_big, 3'b000} - {1'b0, aligned};
        end

        lz = lzc27(sum[26:0]);
        if (sum[27]) begin
            norm    = {sum[27:2], sum[1] | sum[0]};  // Shift right on carry out
            exp_res = $signed({2'b00, exp_big}) + 10'sd1;
        end else begin
            norm    = sum[26:0] << lz;
            exp_res = $signed({2'b00, exp_big}) - $signed({5'd0, lz});
        end

        round_up = norm[2] & (norm[1] | norm[0] | norm[3]);
        man_rnd  = {1'b0, norm[26:3]} + (frac_width + 2)'(round_up);
        if (man_rnd[frac_width+1]) begin
            exp_res = exp_res + 10'sd1;  // Rounded up to the next binade
        end

        if (exp_big == '0 || sum == '0 || exp_res < 10'sd1) begin
            s = '0;
        end else if (exp_res > 10'sd254) begin
            s = {big_op[fp_width-1], {exp_width{1'b1}}, {frac_width{1'b0}}};
        end else begin
            s = {big_op[fp_width-1], exp_res[exp_width-1:0], man_rnd[frac_width-1:0]};
        end
    end

    a_no_nan_inf : assert property (@(posedge clk)
        (a[fp_width-2 -: exp_width] !== {exp_width{1'b1}})
        && (b[fp_width-2 -: exp_width] !== {exp_width{1'b1}}))
        else $error("fp_add: operand with exponent 255");

endmodule

`default_nettype wire

// File: fp_mul.sv
`timescale 1ns/100ps
`default_nettype none

module fp_mul (
    input  logic                         clk,  // Assertion sampling only
    input  logic [pwl_pkg::fp_width-1:0] a,
    input  logic [pwl_pkg::fp_width-1:0] b,
    output logic [pwl_pkg::fp_width-1:0] p
);
    import pwl_pkg::*;

    logic                  sign;
    logic [exp_width-1:0]  exp_a;
    logic [exp_width-1:0]  exp_b;
    logic [frac_width:0]   man_a;        // Hidden one restored
    logic [frac_width:0]   man_b;
    logic [47:0]           prod;
    logic                  norm;         // Product in [2,4)
    logic [frac_width-1:0] frac;
    logic                  guard;
    logic                  sticky;
    logic                  round_up;
    logic [frac_width:0]   frac_rnd;     // Top bit is the rounding carry
    logic signed [9:0]     exp_res;

    assign sign  = a[fp_width-1] ^ b[fp_width-1];
    assign exp_a = a[fp_width-2 -: exp_width];
    assign exp_b = b[fp_width-2 -: exp_width];
    assign man_a = {1'b1, a[frac_width-1:0]};
    assign man_b = {1'b1, b[frac_width-1:0]};

    always_comb begin
        prod = man_a * man_b;
        norm = prod[47];
        if (norm) begin
            frac   = prod[46:24];
            guard  = prod[23];
            sticky = |prod[22:0];
        end else begin
            frac   = prod[45:23];
            guard  = prod[22];
            sticky = |prod[21:0];
        end
        round_up = guard & (sticky | frac[0]);  // Nearest even
        frac_rnd = {1'b0, frac} + (frac_width + 1)'(round_up);
        exp_res  = $signed({2'b00, exp_a}) + $signed({2'b00, exp_b})
                 - $signed(10'(exp_bias)) + $signed({9'd0, norm})
                 + $signed({9'd0, frac_rnd[frac_width]});

        if (exp_a == '0 || exp_b == '0 || exp_res < 10'sd1) begin
            p = '0;  // Zero, subnormal or underflow
        end else if (exp_res > 10'sd254) begin
            p = {sign, {exp_width{1'b1}}, {frac_width{1'b0}}};
        end else begin
            p = {sign, exp_res[exp_width-1:0], frac_rnd[frac_width-1:0]};
        end
    end

    a_no_nan_inf : assert property (@(posedge clk)
        (exp_a !== {exp_width{1'b1}}) && (exp_b !== {exp_width{1'b1}}))
        else $error("fp_mul: operand with exponent 255");

endmodule

`default_nettype wire

// File: pwl_activation.sv
`timescale 1ns/100ps
`default_nettype none

module pwl_activation (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         in_valid,
    input  logic                         func_sel,
    input  logic [pwl_pkg::fp_width-1:0] x,
    output logic                         out_valid,
    output logic [pwl_pkg::fp_width-1:0] y
);
    import pwl_pkg::*;

    logic                     valid_s0;
    logic                     valid_s1;
    logic                     valid_s2;
    logic [fp_width-1:0]      x_s0;
    logic                     func_s0;
    logic [fp_width-1:0]      x_s1;
    logic [fp_width-1:0]      slope_s1;
    logic [fp_width-1:0]      icpt_s1;
    logic [fp_width-1:0]      prod_s2;
    logic [fp_width-1:0]      icpt_s2;

    logic [fp_width-1:0]      breaks [num_breaks];
    logic [seg_idx_width-1:0] seg;
    logic [fp_width-1:0]      slope;
    logic [fp_width-1:0]      icpt;
    logic [fp_width-1:0]      prod;
    logic [fp_width-1:0]      sum;

    pwl_coeff_table u_table (
        .clk      (clk),
        .func_sel (func_s0),
        .seg      (seg),
        .breaks   (breaks),
        .slope    (slope),
        .icpt     (icpt)
    );

    pwl_segment_select u_select (
        .clk    (clk),
        .x      (x_s0),
        .breaks (breaks),
        .seg    (seg)
    );

    fp_mul u_mul (
        .clk (clk),
        .a   (x_s1),
        .b   (slope_s1),
        .p   (prod)
    );

    fp_add u_add (
        .clk (clk),
        .a   (prod_s2),
        .b   (icpt_s2),
        .s   (sum)
    );

    // Payload stages load only behind a valid item
    always_ff @(posedge clk) begin
        if (in_valid) begin
            x_s0    <= x;
            func_s0 <= func_sel;
        end
        if (valid_s0) begin
            x_s1     <= x_s0;
            slope_s1 <= slope;
            icpt_s1  <= icpt;
        end
        if (valid_s1) begin
            prod_s2 <= prod;
            icpt_s2 <= icpt_s1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_s0  <= 1'b0;
            valid_s1  <= 1'b0;
            valid_s2  <= 1'b0;
            out_valid <= 1'b0;
            y         <= '0;
        end else begin
            valid_s0  <= in_valid;
            valid_s1  <= valid_s0;
            valid_s2  <= valid_s1;
            out_valid <= valid_s2;
            if (valid_s2) begin
                y <= sum;  // Held between results
            end
        end
    end

endmodule

`default_nettype wire

// File: pwl_coeff_table.sv
`timescale 1ns/100ps
`default_nettype none

module pwl_coeff_table (
    input  logic                              clk,  // Assertion sampling only
    input  logic                              func_sel,
    input  logic [pwl_pkg::seg_idx_width-1:0] seg,
    output logic [pwl_pkg::fp_width-1:0]      breaks [pwl_pkg::num_breaks],
    output logic [pwl_pkg::fp_width-1:0]      slope,
    output logic [pwl_pkg::fp_width-1:0]      icpt
);
    import pwl_pkg::*;

    logic seg_ok;

    assign seg_ok = (seg < seg_idx_width'(num_segs));

    // Breakpoints depend on the function only
    always_comb begin
        if (func_sel == func_tanh) begin
            breaks = tanh_breaks;
        end else begin
            breaks = sigmoid_breaks;
        end
    end

    always_comb begin
        slope = '0;
        icpt  = '0;
        if (seg_ok) begin
            if (func_sel == func_tanh) begin
                slope = tanh_slope[seg];
                icpt  = tanh_icpt[seg];
            end else begin
                slope = sigmoid_slope[seg];
                icpt  = sigmoid_icpt[seg];
            end
        end
    end

    // Segment index comes from pwl_segment_select and never exceeds 8
    a_seg_range : assert property (@(posedge clk) seg_ok)
        else $error("pwl_coeff_table: segment index %0d out of range", seg);

endmodule

`default_nettype wire

// File: pwl_pkg.sv
`default_nettype none

package pwl_pkg;

    // Single-precision field layout
    localparam int fp_width   = 32;
    localparam int exp_width  = 8;
    localparam int frac_width = 23;
    localparam int exp_bias   = 127;

    localparam int num_breaks    = 8;
    localparam int num_segs      = 9;
    localparam int seg_idx_width = 4;

    localparam logic func_sigmoid = 1'b0;
    localparam logic func_tanh    = 1'b1;

    // Breakpoints ascending, -6 -4 -2 -1 0 1 2 4
    localparam logic [fp_width-1:0] sigmoid_breaks [num_breaks] = '{
        32'hC0C0_0000, 32'hC080_0000, 32'hC000_0000, 32'hBF80_0000,
        32'h0000_0000, 32'h3F80_0000, 32'h4000_0000, 32'h4080_0000
    };

    // Slopes 0 0 1/16 1/8 1/4 1/4 1/8 1/16 0
    localparam logic [fp_width-1:0] sigmoid_slope [num_segs] = '{
        32'h0000_0000, 32'h0000_0000, 32'h3D80_0000,
        32'h3E00_0000, 32'h3E80_0000, 32'h3E80_0000,
        32'h3E00_0000, 32'h3D80_0000, 32'h0000_0000
    };

    // Intercepts 0 0 0.25 0.375 0.5 0.5 0.625 0.75 1
    localparam logic [fp_width-1:0] sigmoid_icpt [num_segs] = '{
        32'h0000_0000, 32'h0000_0000, 32'h3E80_0000,
        32'h3EC0_0000, 32'h3F00_0000, 32'h3F00_0000,
        32'h3F20_0000, 32'h3F40_0000, 32'h3F80_0000
    };

    // tanh(x) = 2*sigmoid(2x) - 1, so breaks halve, slopes times four
    localparam logic [fp_width-1:0] tanh_breaks [num_breaks] = '{
        32'hC040_0000, 32'hC000_0000, 32'hBF80_0000, 32'hBF00_0000,
        32'h0000_0000, 32'h3F00_0000, 32'h3F80_0000, 32'h4000_0000
    };

    localparam logic [fp_width-1:0] tanh_slope [num_segs] = '{
        32'h0000_0000, 32'h0000_0000, 32'h3E80_0000,
        32'h3F00_0000, 32'h3F80_0000, 32'h3F80_0000,
        32'h3F00_0000, 32'h3E80_0000, 32'h0000_0000
    };

    // Intercepts -1 -1 -0.5 -0.25 0 0 0.25 0.5 1
    localparam logic [fp_width-1:0] tanh_icpt [num_segs] = '{
        32'hBF80_0000, 32'hBF80_0000, 32'hBF00_0000,
        32'hBE80_0000, 32'h0000_0000, 32'h0000_0000,
        32'h3E80_0000, 32'h3F00_0000, 32'h3F80_0000
    };

endpackage

`default_nettype wire

// File: pwl_segment_select.sv
`timescale 1ns/100ps
`default_nettype none

module pwl_segment_select (
    input  logic                              clk,  // Assertion sampling only
    input  logic [pwl_pkg::fp_width-1:0]      x,
    input  logic [pwl_pkg::fp_width-1:0]      breaks [pwl_pkg::num_breaks],
    output logic [pwl_pkg::seg_idx_width-1:0] seg
);
    import pwl_pkg::*;

    logic [num_breaks-1:0] below;  // x < breaks[k]
    logic [num_breaks-1:0] flag;   // First breakpoint above x
    logic                  hit;

    // Real-number less-than on sign-magnitude floats
    function automatic logic less_than(logic [fp_width-1:0] a, logic [fp_width-1:0] b);
        logic a_zero;
        logic b_zero;
        a_zero = (a[fp_width-2 -: exp_width] == '0);  // Subnormals count as zero
        b_zero = (b[fp_width-2 -: exp_width] == '0);
        if (a_zero && b_zero) begin
            return 1'b0;  // +0 and -0 are equal
        end else if (a[fp_width-1] != b[fp_width-1]) begin
            return a[fp_width-1];
        end else if (a[fp_width-1]) begin
            // For two negatives the larger magnitude is smaller
            return a[fp_width-2:0] > b[fp_width-2:0];
        end else begin
            return a[fp_width-2:0] < b[fp_width-2:0];
        end
    endfunction

    always_comb begin
        for (int k = 0; k < num_breaks; k++) begin
            below[k] = less_than(x, breaks[k]);
        end
    end

    // Priority chain where the lowest breakpoint wins
    always_comb begin
        hit = 1'b0;
        for (int k = 0; k < num_breaks; k++) begin
            flag[k] = below[k] & ~hit;
            hit     = hit | below[k];
        end
    end

    always_comb begin
        seg = seg_idx_width'(num_breaks);  // Above the last breakpoint
        for (int k = 0; k < num_breaks; k++) begin
            if (flag[k]) begin
                seg = seg_idx_width'(k);
            end
        end
    end

    // Ascending breakpoints turn the comparisons into a thermometer code
    a_below_thermo : assert property (@(posedge clk) ((below << 1) & ~below) == '0)
        else $error("pwl_segment_select: breakpoint comparisons are not monotonic");

endmodule

`default_nettype wire

// File: tb_pwl_activation.sv
`timescale 1ns/100ps
`default_nettype none

module tb_pwl_activation;
    import pwl_pkg::*;

    localparam int tbl_len        = 57;
    localparam int num_random     = 40;
    localparam int num_vectors    = tbl_len + num_random;
    localparam int timeout_cycles = 4 * num_vectors + 50;

    logic                clk;
    logic                rst;
    logic                in_valid;
    logic                func_sel;
    logic [fp_width-1:0] x;
    logic                out_valid;
    logic [fp_width-1:0] y;

    int                  cycle = 0;
    int                  seed;
    int                  value_errs = 0;
    int                  timing_errs = 0;
    int                  other_errs = 0;
    logic [fp_width-1:0] exp_y_q [$];
    int                  exp_cycle_q [$];  // Cycle count at which out_valid is due
    logic [fp_width-1:0] exp_y;
    int                  exp_cycle;
    logic [fp_width-1:0] last_y = '0;

    // Each entry holds func_sel, x, expected segment and idle cycles after the item
    localparam logic [38:0] vec_table [tbl_len] = '{
        {1'b0, 32'hC0C0_0000, 4'd1, 2'd0}, {1'b0, 32'hC0C0_0001, 4'd0, 2'd0},
        {1'b0, 32'hC080_0000, 4'd2, 2'd0}, {1'b0, 32'hC080_0001, 4'd1, 2'd1},
        {1'b0, 32'hC000_0000, 4'd3, 2'd0}, {1'b0, 32'hC000_0001, 4'd2, 2'd0},
        {1'b0, 32'hBF80_0000, 4'd4, 2'd0}, {1'b0, 32'hBF80_0001, 4'd3, 2'd0},
        {1'b0, 32'h0000_0000, 4'd5, 2'd0}, {1'b0, 32'hB380_0000, 4'd4, 2'd0},
        {1'b0, 32'h3F80_0000, 4'd6, 2'd0}, {1'b0, 32'h3F7F_FFFF, 4'd5, 2'd0},
        {1'b0, 32'h4000_0000, 4'd7, 2'd0}, {1'b0, 32'h3FFF_FFFF, 4'd6, 2'd0},
        {1'b0, 32'h4080_0000, 4'd8, 2'd0}, {1'b0, 32'h407F_FFFF, 4'd7, 2'd2},
        // tanh breakpoints
        {1'b1, 32'hC040_0000, 4'd1, 2'd0}, {1'b1, 32'hC040_0001, 4'd0, 2'd0},
        {1'b1, 32'hC000_0000, 4'd2, 2'd0}, {1'b1, 32'hC000_0001, 4'd1, 2'd0},
        {1'b1, 32'hBF80_0000, 4'd3, 2'd0}, {1'b1, 32'hBF80_0001, 4'd2, 2'd1},
        {1'b1, 32'hBF00_0000, 4'd4, 2'd0}, {1'b1, 32'hBF00_0001, 4'd3, 2'd0},
        {1'b1, 32'h0000_0000, 4'd5, 2'd0}, {1'b1, 32'hB380_0000, 4'd4, 2'd0},
        {1'b1, 32'h3F00_0000, 4'd6, 2'd0}, {1'b1, 32'h3EFF_FFFF, 4'd5, 2'd0},
        {1'b1, 32'h3F80_0000, 4'd7, 2'd0}, {1'b1, 32'h3F7F_FFFF, 4'd6, 2'd0},
        {1'b1, 32'h4000_0000, 4'd8, 2'd0}, {1'b1, 32'h3FFF_FFFF, 4'd7, 2'd1},
        // Saturation at +-7 and +-100 with the function switching each item
        {1'b0, 32'h40E0_0000, 4'd8, 2'd0}, {1'b1, 32'h40E0_0000, 4'd8, 2'd0},
        {1'b0, 32'hC0E0_0000, 4'd0, 2'd0}, {1'b1, 32'hC0E0_0000, 4'd0, 2'd0},
        {1'b0, 32'h42C8_0000, 4'd8, 2'd0}, {1'b1, 32'h42C8_0000, 4'd8, 2'd0},
        {1'b0, 32'hC2C8_0000, 4'd0, 2'd0}, {1'b1, 32'hC2C8_0000, 4'd0, 2'd2},
        // Signed zero and mirrored magnitudes
        {1'b0, 32'h0000_0000, 4'd5, 2'd0}, {1'b0, 32'h8000_0000, 4'd5, 2'd0},
        {1'b1, 32'h0000_0000, 4'd5, 2'd0}, {1'b1, 32'h8000_0000, 4'd5, 2'd0},
        {1'b0, 32'hBFC0_0000, 4'd3, 2'd0}, {1'b0, 32'h3FC0_0000, 4'd6, 2'd0},
        {1'b1, 32'hBF40_0000, 4'd3, 2'd0}, {1'b1, 32'h3F40_0000, 4'd6, 2'd1},
        // Rounding cases with ties at 0x40000002, 0x40000006, 0x3F800001, 0x3F800003
        {1'b0, 32'h4000_0002, 4'd7, 2'd0}, {1'b0, 32'h4000_0006, 4'd7, 2'd0},
        {1'b0, 32'h4000_0003, 4'd7, 2'd0}, {1'b0, 32'hC040_0003, 4'd2, 2'd0},
        {1'b1, 32'h3F80_0001, 4'd7, 2'd0}, {1'b1, 32'h3F80_0003, 4'd7, 2'd0},
        // Subnormals behave as zero
        {1'b0, 32'h0000_0001, 4'd5, 2'd0}, {1'b1, 32'h807F_FFFF, 4'd5, 2'd0},
        {1'b0, 32'h8000_0001, 4'd5, 2'd0}
    };

    pwl_activation i_dut (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .func_sel  (func_sel),
        .x         (x),
        .out_valid (out_valid),
        .y         (y)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    // Float bits to real with zero and subnormals giving 0.0
    function automatic real to_real(input logic [fp_width-1:0] v);
        real mag;
        int  e;
        e = int'(v[30:23]);
        if (e == 0) begin
            return 0.0;
        end
        mag = (1.0 + real'(v[22:0]) / 8388608.0) * (2.0 ** (e - 127));
        return v[31] ? -mag : mag;
    endfunction

    // Real to single with round to nearest even and subnormals or -0 flushed to +0
    function automatic logic [fp_width-1:0] to_single(input real r);
        logic [63:0] d;
        logic [24:0] man;  // Hidden one, fraction and rounding carry
        int          e;
        d = $realtobits(r);
        if (d[62:52] == 11'd0) begin
            return '0;
        end
        e   = int'(d[62:52]) - 1023 + exp_bias;
        man = {2'b01, d[51:29]} + 25'(d[28] & (d[29] | (|d[27:0])));
        if (man[24]) begin
            e = e + 1;  // Rounded up to the next power of two
        end
        if (e < 1) begin
            return '0;
        end
        return {d[63], 8'(e), man[22:0]};
    endfunction

    // Smallest k with x below break k, else the top segment
    function automatic int model_seg(input logic f, input logic [fp_width-1:0] xv);
        real xr;
        real br;
        xr = to_real(xv);
        for (int k = 0; k < num_breaks; k++) begin
            br = (f == func_tanh) ? to_real(tanh_breaks[k]) : to_real(sigmoid_breaks[k]);
            if (xr < br) begin
                return k;
            end
        end
        return num_breaks;
    endfunction

    function automatic logic [fp_width-1:0] model_y(input logic f,
                                                    input logic [fp_width-1:0] xv);
        logic [3:0]          seg;
        logic [fp_width-1:0] slope_b;
        logic [fp_width-1:0] icpt_b;
        logic [fp_width-1:0] prod_b;
        seg = 4'(model_seg(f, xv));
        if (f == func_tanh) begin
            slope_b = tanh_slope[seg];
            icpt_b  = tanh_icpt[seg];
        end else begin
            slope_b = sigmoid_slope[seg];
            icpt_b  = sigmoid_icpt[seg];
        end
        prod_b = to_single(to_real(slope_b) * to_real(xv));  // Product rounded first
        return to_single(to_real(prod_b) + to_real(icpt_b));
    endfunction

    // Called 2 ns after an edge, returns 2 ns after the next one
    task automatic drive_item(input logic f, input logic [fp_width-1:0] xv);
        in_valid = 1'b1;
        func_sel = f;
        x        = xv;
        exp_y_q.push_back(model_y(f, xv));
        exp_cycle_q.push_back(cycle + 1 + 3);  // Capture edge, then three stages
        @(posedge clk);
        #2;
        in_valid = 1'b0;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #2;
        end
    endtask

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= timeout_cycles) begin
            $display("Timeout after %0d cycles with %0d results still pending",
                     cycle, exp_y_q.size());
            $display("RESULT: FAIL");
            $finish;
        end
    end

    // Outputs are sampled at the falling edge
    always @(negedge clk) begin
        if (!rst) begin
            if (!out_valid) begin
                assert (y === last_y)
                    else begin
                        $display("ERR y exp %h got %h", last_y, y);
                        value_errs++;
                    end
            end else if (exp_y_q.size() == 0) begin
                $display("out_valid pulse at cycle %0d with no input pending", cycle);
                other_errs++;
            end else begin
                exp_y     = exp_y_q.pop_front();
                exp_cycle = exp_cycle_q.pop_front();
                assert (y === exp_y)
                    else begin
                        $display("ERR y exp %h got %h", exp_y, y);
                        value_errs++;
                    end
                assert (cycle == exp_cycle)
                    else begin
                        $display("Result came at cycle %0d, expected at cycle %0d",
                                 cycle, exp_cycle);
                        timing_errs++;
                    end
            end
        end
        last_y = y;
    end

    initial begin : stimulus
        logic [38:0] ent;
        int          rnd;
        int          rnd_f;
        real         xr;
        seed     = 54;
        rst      = 1'b1;
        in_valid = 1'b0;
        func_sel = 1'b0;
        x        = '0;
        repeat (10) @(posedge clk);
        #2;
        rst = 1'b0;

        @(negedge clk);
        assert (out_valid === 1'b0)
            else begin
                $display("ERR out_valid exp %h got %h", 1'b0, out_valid);
                value_errs++;
            end
        assert (y === '0)
            else begin
                $display("ERR y exp %h got %h", 32'h0, y);
                value_errs++;
            end
        @(posedge clk);
        #2;

        for (int i = 0; i < tbl_len; i++) begin
            ent = vec_table[i];
            assert (model_seg(ent[38], ent[37:6]) == int'(ent[5:2]))
                else begin
                    $display("Table entry %0d lists segment %0d but the model selects %0d",
                             i, ent[5:2], model_seg(ent[38], ent[37:6]));
                    other_errs++;
                end
            drive_item(ent[38], ent[37:6]);
            idle_cycles(int'(ent[1:0]));
        end

        // Random inputs in (-8, 8) with six decimal places
        for (int i = 0; i < num_random; i++) begin
            rnd   = $random(seed);
            rnd_f = $random(seed);
            xr    = real'(rnd % 8000000) / 1.0e6;
            drive_item(rnd_f[0], to_single(xr));
        end

        while (exp_y_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (3) @(posedge clk);

        $display("Errors: value %0d, timing %0d, other %0d",
                 value_errs, timing_errs, other_errs);
        if (value_errs + timing_errs + other_errs == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
